//--- flist.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/cache_ram.sv
hdl/icache_ctrl.sv
hdl/bus_ctrl.sv
hdl/fetch_top.sv
verification/fetch_checker.sv
verification/fetch_tb.sv

//--- hdl/bus_ctrl.sv
`include "fetch_defines.svh"

module bus_ctrl import fetch_pkg::*; (
  input  logic                  clk,
  input  logic                  resetn,

  input  logic                  refill_valid_i,
  input  refill_req_t           refill_req_i,
  output logic                  refill_ready_o,

  output logic                  line_valid_o,
  output line_t                 line_o,

  output logic                  mem_valid_o,
  output mem_req_t              mem_req_o,
  input  logic                  mem_ready_i,
  input  logic [`WORD_BITS-1:0] mem_rdata_i
);

  logic                      busy;
  logic [`WORD_SEL_BITS-1:0] word_cnt;
  logic                      line_valid_q;
  logic [`ADDR_BITS-1:0]     base_q;
  line_t                     line_q;
  logic                      last_word;

  assign last_word = (word_cnt == `WORD_SEL_BITS'(`LINE_WORDS - 1));

  assign refill_ready_o = !busy;
  assign mem_valid_o    = busy;
  // Word address inside the line comes from the counter
  assign mem_req_o.addr = {base_q[`ADDR_BITS-1:`OFFSET_BITS], word_cnt,
                           {`BYTE_SEL_BITS{1'b0}}};

  assign line_valid_o = line_valid_q;
  assign line_o       = line_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      busy         <= 1'b0;
      word_cnt     <= '0;
      line_valid_q <= 1'b0;
    end else begin
      line_valid_q <= 1'b0;
      if (refill_valid_i && refill_ready_o) begin
        busy     <= 1'b1;
        word_cnt <= '0;
      end else if (busy && mem_ready_i) begin
        word_cnt <= word_cnt + 1'b1;
        if (last_word) begin
          busy         <= 1'b0;
          line_valid_q <= 1'b1;
        end
      end
    end
  end

  // Line base and assembled words
  always_ff @(posedge clk) begin
    if (refill_valid_i && refill_ready_o) begin
      base_q <= refill_req_i.base;
    end
    if (busy && mem_ready_i) begin
      line_q.words[word_cnt] <= mem_rdata_i;
    end
  end

  a_addr_stable: assert property (@(posedge clk) disable iff (!resetn)
    (mem_valid_o && !mem_ready_i) |=> (mem_valid_o && $stable(mem_req_o)));

endmodule

//--- hdl/cache_ram.sv
`include "fetch_defines.svh"

module cache_ram #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 16
) (
  input  logic                     clk,
  input  logic                     en_i,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] addr_i,
  input  payload_t                 wdata_i,
  output payload_t                 rdata_o
);

  payload_t mem [DEPTH];
  payload_t rd_pipe [`RAM_LATENCY];

  // Read returns the old contents on a write to the same address
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end
      rd_pipe[0] <= mem[addr_i];
    end
    for (int i = 1; i < `RAM_LATENCY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign rdata_o = rd_pipe[`RAM_LATENCY-1];

endmodule

//--- hdl/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Address and word widths
`define ADDR_BITS     32
`define WORD_BITS     32

// Cache geometry
`define LINE_WORDS    4
`define LINE_BITS     (`LINE_WORDS * `WORD_BITS)
`define SETS          16
`define WAYS          2

// Read latency of the cache RAM blocks in cycles
`define RAM_LATENCY   1

// Derived address fields
`define INDEX_BITS    4
`define OFFSET_BITS   4
`define TAG_BITS      (`ADDR_BITS - `INDEX_BITS - `OFFSET_BITS)

// Word select inside a line, the rest of the offset is the byte lane
`define WORD_SEL_BITS 2
`define BYTE_SEL_BITS (`OFFSET_BITS - `WORD_SEL_BITS)

`endif

//--- hdl/fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

  // Fetch port
  typedef struct packed {
    logic [`ADDR_BITS-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic [`WORD_BITS-1:0] instr;
  } fetch_rsp_t;

  // Tag RAM entry
  typedef struct packed {
    logic                 valid;
    logic [`TAG_BITS-1:0] tag;
  } tag_entry_t;

  // Word 0 sits at the lowest address of the line
  typedef struct packed {
    logic [`LINE_WORDS-1:0][`WORD_BITS-1:0] words;
  } line_t;

  // Line refill towards the bus controller
  typedef struct packed {
    logic [`ADDR_BITS-1:0] base;
  } refill_req_t;

  // Memory bus request, reads only
  typedef struct packed {
    logic [`ADDR_BITS-1:0] addr;
  } mem_req_t;

endpackage

//--- hdl/fetch_top.sv
`include "fetch_defines.svh"

module fetch_top import fetch_pkg::*; (
  input  logic                  clk,
  input  logic                  resetn,

  input  logic                  fetch_req_valid_i,
  input  fetch_req_t            fetch_req_i,
  output logic                  fetch_req_ready_o,
  output logic                  fetch_rsp_valid_o,
  output fetch_rsp_t            fetch_rsp_o,
  input  logic                  fetch_rsp_ready_i,

  output logic                  mem_valid_o,
  output mem_req_t              mem_req_o,
  input  logic                  mem_ready_i,
  input  logic [`WORD_BITS-1:0] mem_rdata_i
);

  logic [`WAYS-1:0]       tag_en;
  logic [`WAYS-1:0]       tag_we;
  logic [`INDEX_BITS-1:0] ram_index;
  tag_entry_t             tag_wdata;
  tag_entry_t             tag_rdata [`WAYS];
  logic [`WAYS-1:0]       data_en;
  logic [`WAYS-1:0]       data_we;
  line_t                  data_wdata;
  line_t                  data_rdata [`WAYS];

  logic                   refill_valid;
  refill_req_t            refill_req;
  logic                   refill_ready;
  logic                   line_valid;
  line_t                  line;

  icache_ctrl ctrl0 (
    .clk               (clk),
    .resetn            (resetn),
    .fetch_req_valid_i (fetch_req_valid_i),
    .fetch_req_i       (fetch_req_i),
    .fetch_req_ready_o (fetch_req_ready_o),
    .fetch_rsp_valid_o (fetch_rsp_valid_o),
    .fetch_rsp_o       (fetch_rsp_o),
    .fetch_rsp_ready_i (fetch_rsp_ready_i),
    .tag_en_o          (tag_en),
    .tag_we_o          (tag_we),
    .ram_index_o       (ram_index),
    .tag_wdata_o       (tag_wdata),
    .tag_rdata_i       (tag_rdata),
    .data_en_o         (data_en),
    .data_we_o         (data_we),
    .data_wdata_o      (data_wdata),
    .data_rdata_i      (data_rdata),
    .refill_valid_o    (refill_valid),
    .refill_req_o      (refill_req),
    .refill_ready_i    (refill_ready),
    .line_valid_i      (line_valid),
    .line_i            (line)
  );

  // Tag and data RAM per way
  for (genvar w = 0; w < `WAYS; w++) begin : g_way
    cache_ram #(.payload_t(tag_entry_t), .DEPTH(`SETS)) tag_ram (
      .clk     (clk),
      .en_i    (tag_en[w]),
      .we_i    (tag_we[w]),
      .addr_i  (ram_index),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rdata[w])
    );

    cache_ram #(.payload_t(line_t), .DEPTH(`SETS)) data_ram (
      .clk     (clk),
      .en_i    (data_en[w]),
      .we_i    (data_we[w]),
      .addr_i  (ram_index),
      .wdata_i (data_wdata),
      .rdata_o (data_rdata[w])
    );
  end

  bus_ctrl bus0 (
    .clk            (clk),
    .resetn         (resetn),
    .refill_valid_i (refill_valid),
    .refill_req_i   (refill_req),
    .refill_ready_o (refill_ready),
    .line_valid_o   (line_valid),
    .line_o         (line),
    .mem_valid_o    (mem_valid_o),
    .mem_req_o      (mem_req_o),
    .mem_ready_i    (mem_ready_i),
    .mem_rdata_i    (mem_rdata_i)
  );

endmodule

//--- hdl/icache_ctrl.sv
`include "fetch_defines.svh"

module icache_ctrl import fetch_pkg::*; (
  input  logic                   clk,
  input  logic                   resetn,

  input  logic                   fetch_req_valid_i,
  input  fetch_req_t             fetch_req_i,
  output logic                   fetch_req_ready_o,
  output logic                   fetch_rsp_valid_o,
  output fetch_rsp_t             fetch_rsp_o,
  input  logic                   fetch_rsp_ready_i,

  output logic [`WAYS-1:0]       tag_en_o,
  output logic [`WAYS-1:0]       tag_we_o,
  output logic [`INDEX_BITS-1:0] ram_index_o,
  output tag_entry_t             tag_wdata_o,
  input  tag_entry_t             tag_rdata_i [`WAYS],

  output logic [`WAYS-1:0]       data_en_o,
  output logic [`WAYS-1:0]       data_we_o,
  output line_t                  data_wdata_o,
  input  line_t                  data_rdata_i [`WAYS],

  output logic                   refill_valid_o,
  output refill_req_t            refill_req_o,
  input  logic                   refill_ready_i,

  input  logic                   line_valid_i,
  input  line_t                  line_i
);

  typedef enum logic [2:0] {
    ST_SWEEP,
    ST_IDLE,
    ST_LOOKUP,
    ST_COMPARE,
    ST_REFILL,
    ST_RESPOND
  } state_t;

  state_t                   state;
  logic [`INDEX_BITS-1:0]   sweep_idx;
  logic [1:0]               lat_cnt;
  logic                     refill_sent;
  // One bit per set is enough with two ways
  logic [`SETS-1:0]         mru;
  fetch_req_t               req_q;
  fetch_rsp_t               rsp_q;

  logic [`TAG_BITS-1:0]      req_tag;
  logic [`INDEX_BITS-1:0]    req_idx;
  logic [`WORD_SEL_BITS-1:0] req_word;
  logic                      victim;
  logic [`WAYS-1:0]          hit;
  logic                      hit_way;
  line_t                     hit_line;

  assign req_tag  = req_q.addr[`ADDR_BITS-1:`INDEX_BITS+`OFFSET_BITS];
  assign req_idx  = req_q.addr[`INDEX_BITS+`OFFSET_BITS-1:`OFFSET_BITS];
  assign req_word = req_q.addr[`OFFSET_BITS-1:`BYTE_SEL_BITS];
  assign victim   = ~mru[req_idx];

  always_comb begin
    hit      = '0;
    hit_way  = 1'b0;
    hit_line = '0;
    for (int w = 0; w < `WAYS; w++) begin
      hit[w] = tag_rdata_i[w].valid && (tag_rdata_i[w].tag == req_tag);
      if (hit[w]) begin
        hit_way  = 1'(w);
        hit_line = data_rdata_i[w];
      end
    end
  end

  // RAM port control
  always_comb begin
    tag_en_o  = '0;
    tag_we_o  = '0;
    data_en_o = '0;
    data_we_o = '0;
    case (state)
      ST_SWEEP: begin
        tag_en_o = '1;
        tag_we_o = '1;
      end
      ST_LOOKUP: begin
        if (lat_cnt == 2'd0) begin
          tag_en_o  = '1;
          data_en_o = '1;
        end
      end
      ST_REFILL: begin
        if (line_valid_i) begin
          tag_en_o[victim]  = 1'b1;
          tag_we_o[victim]  = 1'b1;
          data_en_o[victim] = 1'b1;
          data_we_o[victim] = 1'b1;
        end
      end
      default: ;
    endcase
  end

  assign ram_index_o       = (state == ST_SWEEP) ? sweep_idx : req_idx;
  assign tag_wdata_o.valid = (state != ST_SWEEP);
  assign tag_wdata_o.tag   = (state == ST_SWEEP) ? '0 : req_tag;
  assign data_wdata_o      = line_i;

  assign fetch_req_ready_o = (state == ST_IDLE);
  assign fetch_rsp_valid_o = (state == ST_RESPOND);
  assign fetch_rsp_o       = rsp_q;

  assign refill_valid_o    = (state == ST_REFILL) && !refill_sent;
  assign refill_req_o.base = {req_tag, req_idx, {`OFFSET_BITS{1'b0}}};

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state       <= ST_SWEEP;
      sweep_idx   <= '0;
      lat_cnt     <= '0;
      refill_sent <= 1'b0;
      mru         <= '0;
    end else begin
      case (state)
        ST_SWEEP: begin
          sweep_idx <= sweep_idx + 1'b1;
          if (sweep_idx == `INDEX_BITS'(`SETS - 1)) begin
            state <= ST_IDLE;
          end
        end
        ST_IDLE: begin
          if (fetch_req_valid_i) begin
            state <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          if (lat_cnt == 2'(`RAM_LATENCY - 1)) begin
            lat_cnt <= '0;
            state   <= ST_COMPARE;
          end else begin
            lat_cnt <= lat_cnt + 1'b1;
          end
        end
        ST_COMPARE: begin
          if (|hit) begin
            mru[req_idx] <= hit_way;
            state        <= ST_RESPOND;
          end else begin
            refill_sent <= 1'b0;
            state       <= ST_REFILL;
          end
        end
        ST_REFILL: begin
          if (refill_valid_o && refill_ready_i) begin
            refill_sent <= 1'b1;
          end
          if (line_valid_i) begin
            mru[req_idx] <= victim;
            state        <= ST_RESPOND;
          end
        end
        ST_RESPOND: begin
          if (fetch_rsp_ready_i) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_SWEEP;
      endcase
    end
  end

  // Request address and response word
  always_ff @(posedge clk) begin
    if (fetch_req_valid_i && fetch_req_ready_o) begin
      req_q <= fetch_req_i;
    end
    if (state == ST_COMPARE && |hit) begin
      rsp_q.instr <= hit_line.words[req_word];
    end else if (state == ST_REFILL && line_valid_i) begin
      rsp_q.instr <= line_i.words[req_word];
    end
  end

  a_rsp_stable: assert property (@(posedge clk) disable iff (!resetn)
    (fetch_rsp_valid_o && !fetch_rsp_ready_i)
      |=> (fetch_rsp_valid_o && $stable(fetch_rsp_o)));

  a_single_hit: assert property (@(posedge clk) disable iff (!resetn)
    (state == ST_COMPARE) |-> $onehot0(hit));

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module fetch_tb -f flist.f -o fetch_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/fetch_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

//--- verification/fetch_checker.sv
`include "fetch_defines.svh"

module fetch_checker import fetch_pkg::*; (
  input  logic       clk,
  input  logic       resetn,
  input  logic       req_valid_i,
  input  fetch_req_t req_i,
  input  logic       req_ready_i,
  input  logic       rsp_valid_i,
  input  fetch_rsp_t rsp_i,
  input  logic       rsp_ready_i,
  input  logic       mem_valid_i,
  input  mem_req_t   mem_req_i,
  input  logic       mem_ready_i,
  input  logic       exp_miss_i,
  output int         test_count_o,
  output int         error_count_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int                    cyc = 0;
  int                    req_cyc = 0;
  int                    sweep_cycles = 0;
  int                    reads = 0;
  int                    tests = 0;
  int                    errors = 0;
  int                    errors_at_start = 0;
  logic                  sweep_done = 1'b0;
  logic                  in_flight = 1'b0;
  logic                  rsp_seen = 1'b0;
  logic                  miss_q = 1'b0;
  fetch_req_t            req_q = '0;
  fetch_rsp_t            rsp_hold = '0;
  logic [`ADDR_BITS-1:0] exp_addr;

  assign test_count_o  = tests;
  assign error_count_o = errors;

  // Memory contents follow a fixed rule on the byte address
  function automatic logic [`WORD_BITS-1:0] mem_word(input logic [`ADDR_BITS-1:0] addr);
    return addr ^ 32'h5a3c_0f00;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERROR %s got %h expected %h", name, got, exp);
    errors++;
  endtask

  task automatic report_problem(input string what);
    $display("Cycle %0d: %s", cyc, what);
    errors++;
  endtask

  task automatic finish_test();
    int exp_reads;
    exp_reads = miss_q ? `LINE_WORDS : 0;
    if (rsp_i.instr !== mem_word(req_q.addr)) begin
      report_mismatch("fetch_rsp_o", rsp_i.instr, mem_word(req_q.addr));
    end
    if (reads != exp_reads) begin
      report_problem($sformatf("%0d bus reads for this fetch, expected %0d", reads, exp_reads));
    end
    $display("test %0d addr %h %s, %0d bus reads, %s", tests, req_q.addr,
             miss_q ? "miss" : "hit", reads, (errors == errors_at_start) ? "pass" : "fail");
    tests++;
    in_flight = 1'b0;
  endtask

  always @(posedge clk) begin
    cyc++;
    if (resetn) begin
      // Ready must stay low while the tag sweep runs
      if (!sweep_done) begin
        if (req_ready_i) begin
          if (sweep_cycles < `SETS) begin
            report_problem($sformatf("fetch_req_ready_o rose after only %0d cycles",
                                     sweep_cycles));
          end
          sweep_done = 1'b1;
        end else begin
          sweep_cycles++;
        end
      end
      if (in_flight && req_ready_i) begin
        report_problem("fetch_req_ready_o is high while a fetch is in flight");
      end
      if (mem_valid_i && mem_ready_i) begin
        exp_addr = {req_q.addr[`ADDR_BITS-1:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}}
                   + 32'(reads * (`WORD_BITS / 8));
        if (!in_flight) begin
          report_problem("bus read with no fetch in flight");
        end else if (mem_req_i.addr !== exp_addr) begin
          report_mismatch("mem_req_o", mem_req_i.addr, exp_addr);
        end
        reads++;
      end
      if (rsp_valid_i && !in_flight) begin
        report_problem("fetch_rsp_valid_o is high with no fetch in flight");
      end else if (rsp_valid_i) begin
        if (!rsp_seen) begin
          // Hit answers two cycles after the transfer, first seen on the third edge
          if (!miss_q && (cyc - req_cyc != 3)) begin
            report_problem($sformatf("hit response valid %0d cycles after the transfer, not 2",
                                     cyc - req_cyc - 1));
          end
          rsp_seen = 1'b1;
          rsp_hold = rsp_i;
        end else if (rsp_i !== rsp_hold) begin
          report_mismatch("fetch_rsp_o", rsp_i.instr, rsp_hold.instr);
        end
        if (rsp_ready_i) begin
          finish_test();
        end
      end
      if (req_valid_i && req_ready_i) begin
        in_flight       = 1'b1;
        rsp_seen        = 1'b0;
        reads           = 0;
        req_q           = req_i;
        miss_q          = exp_miss_i;
        req_cyc         = cyc;
        errors_at_start = errors;
      end
    end
  end

endmodule

//--- verification/fetch_tb.sv
`include "fetch_defines.svh"

module fetch_tb import fetch_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic [`ADDR_BITS-1:0] addr;
    logic                  miss;
    logic [3:0]            stall;
  } stim_t;

  localparam int NUM_TESTS      = 14;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * (`LINE_WORDS * 5 + 20) + `SETS + 3;

  // Lines A, B and C share index 4 with tags 0x10, 0x20 and 0x30
  localparam stim_t STIM [NUM_TESTS] = '{
    '{32'h0000_1040, 1'b1, 4'd0},
    '{32'h0000_1048, 1'b0, 4'd0},
    '{32'h0000_104c, 1'b0, 4'd3},
    '{32'h0000_2044, 1'b1, 4'd0},
    '{32'h0000_1044, 1'b0, 4'd0},
    '{32'h0000_2048, 1'b0, 4'd0},
    '{32'h0000_3040, 1'b1, 4'd1},
    '{32'h0000_2040, 1'b0, 4'd0},
    '{32'h0000_104c, 1'b1, 4'd0},
    '{32'h0000_204c, 1'b0, 4'd5},
    '{32'h0000_3044, 1'b1, 4'd2},
    '{32'h0000_1040, 1'b1, 4'd0},
    '{32'h0000_0ff0, 1'b1, 4'd4},
    '{32'h0000_0ffc, 1'b0, 4'd4}
  };

  logic                  clk;
  logic                  resetn;
  logic                  req_valid;
  fetch_req_t            req;
  logic                  req_ready;
  logic                  rsp_valid;
  fetch_rsp_t            rsp;
  logic                  rsp_ready;
  logic                  mem_valid;
  mem_req_t              mem_req;
  logic                  mem_ready;
  logic [`WORD_BITS-1:0] mem_rdata;
  logic                  exp_miss;
  int                    test_count;
  int                    error_count;
  logic [31:0]           lfsr;

  // Fibonacci LFSR with taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [`WORD_BITS-1:0] mem_word(input logic [`ADDR_BITS-1:0] addr);
    return addr ^ 32'h5a3c_0f00;
  endfunction

  fetch_top dut0 (
    .clk               (clk),
    .resetn            (resetn),
    .fetch_req_valid_i (req_valid),
    .fetch_req_i       (req),
    .fetch_req_ready_o (req_ready),
    .fetch_rsp_valid_o (rsp_valid),
    .fetch_rsp_o       (rsp),
    .fetch_rsp_ready_i (rsp_ready),
    .mem_valid_o       (mem_valid),
    .mem_req_o         (mem_req),
    .mem_ready_i       (mem_ready),
    .mem_rdata_i       (mem_rdata)
  );

  fetch_checker chk0 (
    .clk           (clk),
    .resetn        (resetn),
    .req_valid_i   (req_valid),
    .req_i         (req),
    .req_ready_i   (req_ready),
    .rsp_valid_i   (rsp_valid),
    .rsp_i         (rsp),
    .rsp_ready_i   (rsp_ready),
    .mem_valid_i   (mem_valid),
    .mem_req_i     (mem_req),
    .mem_ready_i   (mem_ready),
    .exp_miss_i    (exp_miss),
    .test_count_o  (test_count),
    .error_count_o (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Memory answers each read after 0 to 3 cycles
  initial begin
    logic [1:0] delay;
    logic       armed;
    mem_ready = 1'b0;
    mem_rdata = '0;
    lfsr      = 32'h4025_dc2e;
    delay     = '0;
    armed     = 1'b0;
    forever begin
      @(posedge clk);
      if (!resetn || mem_ready) begin
        mem_ready <= 1'b0;
        armed = 1'b0;
      end else if (mem_valid) begin
        if (!armed) begin
          for (int b = 0; b < 2; b++) begin
            lfsr  = lfsr_step(lfsr);
            delay = {delay[0], lfsr[0]};
          end
          armed = 1'b1;
        end
        if (delay == 2'd0) begin
          mem_ready <= 1'b1;
          mem_rdata <= mem_word(mem_req.addr);
          armed = 1'b0;
        end else begin
          delay = delay - 2'd1;
        end
      end
    end
  end

  initial begin
    resetn    = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b0;
    exp_miss  = 1'b0;
    repeat (3) @(posedge clk);
    resetn <= 1'b1;
    for (int i = 0; i < NUM_TESTS; i++) begin
      req_valid <= 1'b1;
      req.addr  <= STIM[i].addr;
      exp_miss  <= STIM[i].miss;
      do @(posedge clk); while (!req_ready);
      req_valid <= 1'b0;
      do @(posedge clk); while (!rsp_valid);
      repeat (STIM[i].stall) @(posedge clk);
      rsp_ready <= 1'b1;
      @(posedge clk);
      rsp_ready <= 1'b0;
    end
    repeat (2) @(posedge clk);
    $display("%0d of %0d tests done, %0d errors", test_count, NUM_TESTS, error_count);
    if (error_count == 0 && test_count == NUM_TESTS) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the fetch sequence did not complete", TIMEOUT_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule
